// File: class_neuron.sv
`timescale 1ns/1ps

module class_neuron #(
    parameter int CLASS_ID = 0
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  pixel_valid,
    input  logic                                  pixel,
    input  logic [digit_pkg::PIX_IDX_W-1:0]       pixel_index,
    input  logic                                  first,
    output logic signed [digit_pkg::SCORE_W-1:0]  score
);

    localparam int EXT_W = digit_pkg::SCORE_W - digit_pkg::WEIGHT_W;

    // ============================================================
    // weight of the current beat
    // ============================================================

    logic signed [digit_pkg::WEIGHT_W-1:0] weight;
    logic signed [digit_pkg::SCORE_W-1:0]  weight_ext;
    logic signed [digit_pkg::SCORE_W-1:0]  contrib;

    // the weight is recomputed for every beat from the class and index.
    assign weight = digit_pkg::weight_of(digit_pkg::CLASS_W'(CLASS_ID), pixel_index);

    assign weight_ext = {{EXT_W{weight[digit_pkg::WEIGHT_W-1]}}, weight};

    // a clear pixel adds nothing.
    assign contrib = pixel ? weight_ext : '0;

    // ============================================================
    // accumulator
    // ============================================================

    // the first beat of an image replaces whatever the last image left.
    always_ff @(posedge clk) begin
        if (rst) begin
            score <= '0;
        end else if (pixel_valid) begin
            if (first) begin
                score <= contrib;
            end else begin
                score <= score + contrib;
            end
        end
    end

endmodule

// File: digit_pkg.sv
package digit_pkg;

    // ============================================================
    // image and score sizes
    // ============================================================

    // the raw image is 52 by 52 and the network sees 28 by 28.
    localparam int SRC_SIDE   = 52;
    localparam int DST_SIDE   = 28;
    localparam int SRC_PIXELS = SRC_SIDE * SRC_SIDE;
    localparam int NUM_PIXELS = DST_SIDE * DST_SIDE;

    localparam int NUM_CLASSES = 10;
    localparam int PIX_IDX_W   = 10;
    localparam int WEIGHT_W    = 8;
    localparam int SCORE_W     = 32;
    localparam int CLASS_W     = 4;

    // ============================================================
    // control states of the top level
    // ============================================================

    localparam int STATE_W = 2;

    localparam logic [STATE_W-1:0] ST_WAIT    = 2'd0;
    localparam logic [STATE_W-1:0] ST_CAPTURE = 2'd1;
    localparam logic [STATE_W-1:0] ST_PROCESS = 2'd2;
    localparam logic [STATE_W-1:0] ST_FIN     = 2'd3;

    // ============================================================
    // weight rule
    // ============================================================

    // the weight of a pixel for a class is a fixed arithmetic mix of both indices.
    // only the low byte is kept, and it is read as a two's complement number.
    function automatic logic signed [WEIGHT_W-1:0] weight_of(
        input logic [CLASS_W-1:0]   cls,
        input logic [PIX_IDX_W-1:0] idx
    );
        int unsigned p;
        int unsigned c;
        int unsigned sum;
        p   = idx;
        c   = cls;
        sum = p * 7 + c * 59 + (p / 8) * c;
        return WEIGHT_W'(sum);
    endfunction

endpackage

// File: digit_predictor.sv
`timescale 1ns/1ps

module digit_predictor (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  logic [digit_pkg::SRC_PIXELS-1:0] track_input,
    output logic [digit_pkg::CLASS_W-1:0]    predicted_number,
    output logic                             finish
);

    // ============================================================
    // signals
    // ============================================================

    logic [digit_pkg::STATE_W-1:0]    state;
    logic [digit_pkg::STATE_W-1:0]    next_state;
    logic                             go;

    logic [digit_pkg::NUM_PIXELS-1:0] scaled_img;
    logic [digit_pkg::NUM_PIXELS-1:0] captured_img;

    logic                             pixel_valid;
    logic                             pixel;
    logic [digit_pkg::PIX_IDX_W-1:0]  pixel_index;
    logic                             first;
    logic                             last;

    logic signed [digit_pkg::SCORE_W-1:0] scores [digit_pkg::NUM_CLASSES];

    // ============================================================
    // control FSM
    // ============================================================

    always_comb begin
        next_state = state;
        case (state)
            digit_pkg::ST_WAIT: begin
                if (start) begin
                    next_state = digit_pkg::ST_CAPTURE;
                end
            end
            digit_pkg::ST_CAPTURE: next_state = digit_pkg::ST_PROCESS;
            digit_pkg::ST_PROCESS: begin
                if (finish) begin
                    next_state = digit_pkg::ST_FIN;
                end
            end
            default: next_state = digit_pkg::ST_WAIT;
        endcase
    end

    // go is a registered one-cycle pulse following the CAPTURE state.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= digit_pkg::ST_WAIT;
            go    <= 1'b0;
        end else begin
            state <= next_state;
            go    <= (state == digit_pkg::ST_CAPTURE);
        end
    end

    // the scaled image is taken only on an accepted start.
    always_ff @(posedge clk) begin
        if (state == digit_pkg::ST_WAIT && start) begin
            captured_img <= scaled_img;
        end
    end

    // ============================================================
    // datapath
    // ============================================================

    image_scaler u_scaler (
        .img        (track_input),
        .scaled_img (scaled_img)
    );

    pixel_streamer u_streamer (
        .clk         (clk),
        .rst         (rst),
        .go          (go),
        .image       (captured_img),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .pixel_index (pixel_index),
        .first       (first),
        .last        (last)
    );

    // one accumulator per digit, all fed by the same pixel stream.
    genvar g;
    generate
        for (g = 0; g < digit_pkg::NUM_CLASSES; g++) begin : g_neuron
            class_neuron #(
                .CLASS_ID (g)
            ) u_neuron (
                .clk         (clk),
                .rst         (rst),
                .pixel_valid (pixel_valid),
                .pixel       (pixel),
                .pixel_index (pixel_index),
                .first       (first),
                .score       (scores[g])
            );
        end
    endgenerate

    score_argmax u_argmax (
        .clk         (clk),
        .rst         (rst),
        .last        (last),
        .pixel_valid (pixel_valid),
        .score_0     (scores[0]),
        .score_1     (scores[1]),
        .score_2     (scores[2]),
        .score_3     (scores[3]),
        .score_4     (scores[4]),
        .score_5     (scores[5]),
        .score_6     (scores[6]),
        .score_7     (scores[7]),
        .score_8     (scores[8]),
        .score_9     (scores[9]),
        .number      (predicted_number),
        .finish      (finish)
    );

endmodule

// File: image_scaler.sv
`timescale 1ns/1ps

module image_scaler (
    input  logic [digit_pkg::SRC_PIXELS-1:0] img,
    output logic [digit_pkg::NUM_PIXELS-1:0] scaled_img
);

    // ============================================================
    // nearest-neighbor map
    // ============================================================

    // every output pixel picks one source pixel.  The source row and
    // column are the destination ones scaled by 52/28, rounded down.
    // Both images are row-major, so bit index is row times side plus
    // column.

    genvar row;
    genvar col;

    generate
        for (row = 0; row < digit_pkg::DST_SIDE; row++) begin : g_row
            // source row for this output row.
            localparam int SRC_ROW = (row * digit_pkg::SRC_SIDE) / digit_pkg::DST_SIDE;

            for (col = 0; col < digit_pkg::DST_SIDE; col++) begin : g_col
                localparam int SRC_COL = (col * digit_pkg::SRC_SIDE) / digit_pkg::DST_SIDE;
                localparam int DST_BIT = row * digit_pkg::DST_SIDE + col;
                localparam int SRC_BIT = SRC_ROW * digit_pkg::SRC_SIDE + SRC_COL;

                assign scaled_img[DST_BIT] = img[SRC_BIT];
            end
        end
    endgenerate

    // for reference, the first few source columns picked are
    // 0, 1, 3, 5, 7, 9, 11, 13, 14 and so on.  The last output
    // column reads source column 50, so column 51 and row 51 are
    // never sampled.

endmodule

// File: pixel_streamer.sv
`timescale 1ns/1ps

module pixel_streamer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             go,
    input  logic [digit_pkg::NUM_PIXELS-1:0] image,
    output logic                             pixel_valid,
    output logic                             pixel,
    output logic [digit_pkg::PIX_IDX_W-1:0]  pixel_index,
    output logic                             first,
    output logic                             last
);

    localparam logic [digit_pkg::PIX_IDX_W-1:0] LAST_IDX =
        digit_pkg::PIX_IDX_W'(digit_pkg::NUM_PIXELS - 1);

    // ============================================================
    // walk state
    // ============================================================

    logic                            busy;
    logic [digit_pkg::PIX_IDX_W-1:0] idx;
    logic [digit_pkg::PIX_IDX_W-1:0] cur_idx;
    logic                            active;

    // go starts the walk at index 0 in the same edge, so the first
    // beat is on the outputs the cycle after go.
    assign active  = go | busy;
    assign cur_idx = go ? '0 : idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (go) begin
            busy <= 1'b1;
            idx  <= digit_pkg::PIX_IDX_W'(1);
        end else if (busy) begin
            if (idx == LAST_IDX) begin
                busy <= 1'b0;
                idx  <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // ============================================================
    // registered beat
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            pixel_valid <= 1'b0;
            first       <= 1'b0;
            last        <= 1'b0;
        end else begin
            pixel_valid <= active;
            first       <= active & (cur_idx == '0);
            last        <= active & (cur_idx == LAST_IDX);
        end
    end

    // the pixel and its index only mean something while pixel_valid is high.
    always_ff @(posedge clk) begin
        if (active) begin
            pixel       <= image[cur_idx];
            pixel_index <= cur_idx;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Compile and run the digit predictor testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_digit_predictor -o sim_digit_predictor

output="$(./obj_dir/sim_digit_predictor)"
echo "$output"

if grep -qF -- '** PASS **' <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: score_argmax.sv
`timescale 1ns/1ps

module score_argmax (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 last,
    input  logic                                 pixel_valid,
    input  logic signed [digit_pkg::SCORE_W-1:0] score_0,
    input  logic signed [digit_pkg::SCORE_W-1:0] score_1,
    input  logic signed [digit_pkg::SCORE_W-1:0] score_2,
    input  logic signed [digit_pkg::SCORE_W-1:0] score_3,
    input  logic signed [digit_pkg::SCORE_W-1:0] score_4,
    input  logic signed [digit_pkg::SCORE_W-1:0] score_5,
    input  logic signed [digit_pkg::SCORE_W-1:0] score_6,
    input  logic signed [digit_pkg::SCORE_W-1:0] score_7,
    input  logic signed [digit_pkg::SCORE_W-1:0] score_8,
    input  logic signed [digit_pkg::SCORE_W-1:0] score_9,
    output logic [digit_pkg::CLASS_W-1:0]        number,
    output logic                                 finish
);

    logic signed [digit_pkg::SCORE_W-1:0] scores [digit_pkg::NUM_CLASSES];

    assign scores[0] = score_0;
    assign scores[1] = score_1;
    assign scores[2] = score_2;
    assign scores[3] = score_3;
    assign scores[4] = score_4;
    assign scores[5] = score_5;
    assign scores[6] = score_6;
    assign scores[7] = score_7;
    assign scores[8] = score_8;
    assign scores[9] = score_9;

    // ============================================================
    // search for the largest score
    // ============================================================

    logic [digit_pkg::CLASS_W-1:0]        best_idx;
    logic signed [digit_pkg::SCORE_W-1:0] best_val;

    // strict compare from class 0 upward, so a tie keeps the lower class.
    always_comb begin
        best_idx = '0;
        best_val = scores[0];
        for (int i = 1; i < digit_pkg::NUM_CLASSES; i++) begin
            if (scores[i] > best_val) begin
                best_idx = digit_pkg::CLASS_W'(i);
                best_val = scores[i];
            end
        end
    end

    // ============================================================
    // result registers
    // ============================================================

    logic last_d;

    // the scores settle one edge after the last beat, hence the delay.
    always_ff @(posedge clk) begin
        if (rst) begin
            last_d <= 1'b0;
            finish <= 1'b0;
            number <= '0;
        end else begin
            last_d <= last & pixel_valid;
            finish <= last_d;
            if (last_d) begin
                number <= best_idx;
            end
        end
    end

endmodule

// File: tb.f
digit_pkg.sv
image_scaler.sv
pixel_streamer.sv
class_neuron.sv
score_argmax.sv
digit_predictor.sv
tb_digit_predictor.sv

// File: tb_digit_predictor.sv
`timescale 1ns/1ps

module tb_digit_predictor;

    // finish is high in this cycle when start is sampled at edge 0.
    localparam int FINISH_CYCLE   = 787;
    localparam int NUM_RANDOM     = 30;
    localparam int WATCH_CYCLES   = 800;
    localparam int TIMEOUT_CYCLES = 40 * 800 + 2000;

    logic                             clk;
    logic                             rst;
    logic                             start;
    logic [digit_pkg::SRC_PIXELS-1:0] track_input;
    logic [digit_pkg::CLASS_W-1:0]    predicted_number;
    logic                             finish;

    logic [digit_pkg::CLASS_W-1:0]    last_result;
    integer                           seed = 32'hc011ff04;
    int                               error_count;
    int                               check_count;
    int                               cycle_count;

    digit_predictor uut (
        .clk              (clk),
        .rst              (rst),
        .start            (start),
        .track_input      (track_input),
        .predicted_number (predicted_number),
        .finish           (finish)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ============================================================
    // reference model
    // ============================================================

    // the weight rule, worked out with plain integers and folded to a signed byte.
    function automatic int weight_rule(input int cls, input int p);
        int w;
        w = (p * 7 + cls * 59 + (p / 8) * cls) % 256;
        if (w > 127) begin
            w = w - 256;
        end
        return w;
    endfunction

    // scale by nearest neighbor, score every class and take the first maximum.
    function automatic logic [digit_pkg::CLASS_W-1:0] predict_digit(
        input logic [digit_pkg::SRC_PIXELS-1:0] img
    );
        int score [digit_pkg::NUM_CLASSES];
        int row;
        int col;
        int sr;
        int sc;
        int cls;
        int best;
        for (cls = 0; cls < digit_pkg::NUM_CLASSES; cls++) begin
            score[cls] = 0;
        end
        for (row = 0; row < digit_pkg::DST_SIDE; row++) begin
            for (col = 0; col < digit_pkg::DST_SIDE; col++) begin
                sr = (row * digit_pkg::SRC_SIDE) / digit_pkg::DST_SIDE;
                sc = (col * digit_pkg::SRC_SIDE) / digit_pkg::DST_SIDE;
                if (img[sr * digit_pkg::SRC_SIDE + sc]) begin
                    for (cls = 0; cls < digit_pkg::NUM_CLASSES; cls++) begin
                        score[cls] += weight_rule(cls, row * digit_pkg::DST_SIDE + col);
                    end
                end
            end
        end
        best = 0;
        for (cls = 1; cls < digit_pkg::NUM_CLASSES; cls++) begin
            if (score[cls] > score[best]) begin
                best = cls;
            end
        end
        return digit_pkg::CLASS_W'(best);
    endfunction

    // ============================================================
    // helpers
    // ============================================================

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    // a sparse image keeps about a quarter of the pixels set.
    task automatic make_random_image(output logic [digit_pkg::SRC_PIXELS-1:0] img,
                                     input bit sparse);
        logic [2719:0] raw;
        int k;
        for (k = 0; k < 85; k++) begin
            raw[k*32 +: 32] = $random(seed);
            if (sparse) begin
                raw[k*32 +: 32] = raw[k*32 +: 32] & $random(seed);
            end
        end
        img = raw[digit_pkg::SRC_PIXELS-1:0];
    endtask

    // the caller is at a falling edge in a WAIT cycle.  The task returns at the
    // falling edge of the first WAIT cycle after FIN, so calls run back to back.
    task automatic run_image(input logic [digit_pkg::SRC_PIXELS-1:0] img,
                             input logic [digit_pkg::SRC_PIXELS-1:0] other,
                             input bit disturb);
        logic [digit_pkg::CLASS_W-1:0] expected;
        int cyc;
        bit seen;
        expected    = predict_digit(img);
        track_input = img;
        start       = 1'b1;
        cyc         = -1;
        seen        = 1'b0;
        while (!seen) begin
            @(negedge clk);
            cyc++;
            if (cyc == 0) begin
                start       = 1'b0;
                track_input = other;
            end
            // a second start in PROCESS with another image on the input.
            if (disturb && cyc == 300) begin
                start = 1'b1;
            end
            if (disturb && cyc == 301) begin
                start = 1'b0;
            end
            if (finish) begin
                seen = 1'b1;
            end else begin
                check_equal("predicted_number", 32'(predicted_number), 32'(last_result));
            end
        end
        check_equal("finish_cycle", cyc, FINISH_CYCLE);
        check_equal("predicted_number", 32'(predicted_number), 32'(expected));
        last_result = expected;
        @(negedge clk);
        check_equal("finish", 32'(finish), 32'd0);
        // this start lands in FIN and must be dropped as well.
        if (disturb) begin
            start = 1'b1;
        end
        @(negedge clk);
        start = 1'b0;
        check_equal("predicted_number", 32'(predicted_number), 32'(last_result));
    endtask

    // ============================================================
    // stimulus
    // ============================================================

    initial begin
        logic [digit_pkg::SRC_PIXELS-1:0] img;
        logic [digit_pkg::SRC_PIXELS-1:0] other;
        int n;
        int r;
        int c;
        rst         = 1'b1;
        start       = 1'b0;
        track_input = '0;
        last_result = '0;
        error_count = 0;
        check_count = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // outputs stay quiet after reset until the first start.
        repeat (4) begin
            @(negedge clk);
            check_equal("finish", 32'(finish), 32'd0);
            check_equal("predicted_number", 32'(predicted_number), 32'd0);
        end

        for (n = 0; n < NUM_RANDOM; n++) begin
            make_random_image(img, (n % 2) == 1);
            make_random_image(other, 1'b0);
            run_image(img, other, 1'b0);
        end

        make_random_image(other, 1'b0);
        run_image('0, other, 1'b0);
        run_image('1, other, 1'b0);

        // only the top left corner is sampled, since row and column 51 are skipped.
        for (n = 0; n < 4; n++) begin
            r = (n / 2) * (digit_pkg::SRC_SIDE - 1);
            c = (n % 2) * (digit_pkg::SRC_SIDE - 1);
            img = '0;
            img[r * digit_pkg::SRC_SIDE + c] = 1'b1;
            run_image(img, other, 1'b0);
        end

        make_random_image(img, 1'b1);
        make_random_image(other, 1'b0);
        run_image(img, other, 1'b1);

        // neither dropped start may have begun another pass.
        repeat (WATCH_CYCLES) begin
            @(negedge clk);
            check_equal("finish", 32'(finish), 32'd0);
            check_equal("predicted_number", 32'(predicted_number), 32'(last_result));
        end

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // ============================================================
    // timeout
    // ============================================================

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("the run timed out after %0d cycles before all tests ended", cycle_count);
        $display("** FAIL **");
        $finish;
    end

endmodule
